/* common/rv_isa_pkg.sv */
package rv_isa_pkg;

    // ----------------------------------------
    // basic widths
    // ----------------------------------------
    localparam int XLEN = 32;

    typedef logic [4:0] reg_idx_t;

    // ----------------------------------------
    // major opcodes, bits [6:0]
    // ----------------------------------------
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // alu funct3, shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

endpackage

/* common/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

    // ----------------------------------------
    // alu operation, carried in ID/EX
    // ----------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        // lui, immediate straight through
        ALU_PASS_B
    } alu_op_e;

    // ----------------------------------------
    // operand forward select into EX
    // ----------------------------------------
    typedef enum logic [1:0] {
        // value read in decode
        FWD_NONE,
        // alu result sitting in EX/MEM
        FWD_MEM,
        // final writeback value
        FWD_WB
    } fwd_sel_e;

endpackage

/* src/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import rv_isa_pkg::*; #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            imem_we,
    input  logic [7:0]      imem_waddr,
    input  logic [XLEN-1:0] imem_wdata,
    input  logic            stall,
    input  logic            flush,
    input  logic            redirect,
    input  logic [XLEN-1:0] redirect_pc,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] pc_id,
    output logic [XLEN-1:0] instr_id
);
    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    logic [XLEN-1:0] imem [IMEM_DEPTH];
    logic [XLEN-1:0] instr_if;

    // program load port, driven while the core sits in reset
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_waddr] <= imem_wdata;
        end
    end

    // async read, word index from pc
    assign instr_if = imem[pc[IMEM_AW+1:2]];

    // ----------------------------------------
    // pc, redirect beats stall
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            // static not-taken
            pc <= pc + XLEN'(4);
        end
    end

    // ----------------------------------------
    // IF/ID register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_id <= NOP_INSTR;
            pc_id    <= '0;
        end else if (flush) begin
            // wrong-path fetch becomes a nop
            instr_id <= NOP_INSTR;
        end else if (!stall) begin
            instr_id <= instr_if;
            pc_id    <= pc;
        end
    end

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [XLEN-1:0] instr_id,
    input  logic [XLEN-1:0] pc_id,
    input  logic            stall,
    input  logic            flush,
    input  reg_idx_t        rd_wb,
    input  logic            reg_write_wb,
    input  logic [XLEN-1:0] wb_data,
    output reg_idx_t        rs1_id,
    output reg_idx_t        rs2_id,
    output reg_idx_t        rs1_ex,
    output reg_idx_t        rs2_ex,
    output reg_idx_t        rd_ex,
    output logic [XLEN-1:0] imm_ex,
    output logic [XLEN-1:0] pc_ex,
    output logic [XLEN-1:0] rs1_data_ex,
    output logic [XLEN-1:0] rs2_data_ex,
    output alu_op_e         alu_op_ex,
    output logic            alu_src_ex,
    output logic            mem_write_ex,
    output logic            mem_to_reg_ex,
    output logic            reg_write_ex,
    output logic            branch_ex,
    output logic            jal_ex,
    output logic            jalr_ex,
    output logic [2:0]      funct3_ex
);
    opcode_e         opcode;
    logic [2:0]      funct3;
    reg_idx_t        rd;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm;
    alu_op_e         alu_op;
    logic            alu_src;
    logic            mem_write;
    logic            mem_to_reg;
    logic            writes_rd;
    logic            branch;
    logic            jal;
    logic            jalr;
    logic            use_rs1;
    logic            use_rs2;
    logic            bubble;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    // x0 is hardwired, no storage for it
    logic [XLEN-1:0] regs [1:31];

    // funct3 (+ funct7 bit 5 for OP) to alu operation
    function automatic alu_op_e alu_op_of(input logic [2:0] f3, input logic sub);
        case (f3)
            F3_ADD_SUB: return sub ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_XOR:     return ALU_XOR;
            F3_SRL:     return ALU_SRL;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;
        endcase
    endfunction

    // ----------------------------------------
    // fields and immediates
    // ----------------------------------------
    assign opcode = opcode_e'(instr_id[6:0]);
    assign funct3 = instr_id[14:12];
    assign rd     = instr_id[11:7];

    assign imm_i = {{20{instr_id[31]}}, instr_id[31:20]};
    assign imm_s = {{20{instr_id[31]}}, instr_id[31:25], instr_id[11:7]};
    assign imm_b = {{19{instr_id[31]}}, instr_id[31], instr_id[7],
                    instr_id[30:25], instr_id[11:8], 1'b0};
    assign imm_u = {instr_id[31:12], 12'b0};
    assign imm_j = {{11{instr_id[31]}}, instr_id[31], instr_id[19:12],
                    instr_id[20], instr_id[30:21], 1'b0};

    // ----------------------------------------
    // control decode
    // ----------------------------------------
    always_comb begin
        alu_op     = ALU_ADD;
        alu_src    = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        writes_rd  = 1'b0;
        branch     = 1'b0;
        jal        = 1'b0;
        jalr       = 1'b0;
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        imm        = imm_i;
        case (opcode)
            OPC_OP: begin
                alu_op    = alu_op_of(funct3, instr_id[30]);
                writes_rd = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op    = alu_op_of(funct3, 1'b0);
                alu_src   = 1'b1;
                writes_rd = 1'b1;
                use_rs1   = 1'b1;
            end
            OPC_LUI: begin
                alu_op    = ALU_PASS_B;
                alu_src   = 1'b1;
                writes_rd = 1'b1;
                imm       = imm_u;
            end
            OPC_LOAD: begin
                alu_src    = 1'b1;
                mem_to_reg = 1'b1;
                writes_rd  = 1'b1;
                use_rs1    = 1'b1;
            end
            OPC_STORE: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                imm       = imm_s;
            end
            OPC_BRANCH: begin
                branch  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm     = imm_b;
            end
            OPC_JAL: begin
                jal       = 1'b1;
                writes_rd = 1'b1;
                imm       = imm_j;
            end
            OPC_JALR: begin
                jalr      = 1'b1;
                writes_rd = 1'b1;
                use_rs1   = 1'b1;
            end
            // unknown opcode retires as a nop
            default: ;
        endcase
    end

    // unused source fields read as x0 so the hazard unit sees no false match
    assign rs1_id = use_rs1 ? instr_id[19:15] : '0;
    assign rs2_id = use_rs2 ? instr_id[24:20] : '0;

    // ----------------------------------------
    // register file
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reg_write_wb) begin
            regs[rd_wb] <= wb_data;
        end
    end

    // write-before-read, same-cycle writeback wins
    always_comb begin
        if (rs1_id == '0) begin
            rs1_data = '0;
        end else if (reg_write_wb && rd_wb == rs1_id) begin
            rs1_data = wb_data;
        end else begin
            rs1_data = regs[rs1_id];
        end
    end

    always_comb begin
        if (rs2_id == '0) begin
            rs2_data = '0;
        end else if (reg_write_wb && rd_wb == rs2_id) begin
            rs2_data = wb_data;
        end else begin
            rs2_data = regs[rs2_id];
        end
    end

    // ----------------------------------------
    // ID/EX register
    // ----------------------------------------
    assign bubble = stall || flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_write_ex  <= 1'b0;
            mem_to_reg_ex <= 1'b0;
            reg_write_ex  <= 1'b0;
            branch_ex     <= 1'b0;
            jal_ex        <= 1'b0;
            jalr_ex       <= 1'b0;
        end else begin
            mem_write_ex  <= mem_write && !bubble;
            mem_to_reg_ex <= mem_to_reg && !bubble;
            // rd of x0 never asks for a write
            reg_write_ex  <= writes_rd && (rd != '0) && !bubble;
            branch_ex     <= branch && !bubble;
            jal_ex        <= jal && !bubble;
            jalr_ex       <= jalr && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        rs1_ex      <= rs1_id;
        rs2_ex      <= rs2_id;
        rd_ex       <= rd;
        imm_ex      <= imm;
        pc_ex       <= pc_id;
        rs1_data_ex <= rs1_data;
        rs2_data_ex <= rs2_data;
        alu_op_ex   <= alu_op;
        alu_src_ex  <= alu_src;
        funct3_ex   <= funct3;
    end

    // x0 filtering upstream keeps every register-file write off x0
    assert property (@(posedge clk) disable iff (!rst_n) reg_write_wb |-> rd_wb != '0);

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  reg_idx_t        rd_ex,
    input  logic [XLEN-1:0] imm_ex,
    input  logic [XLEN-1:0] pc_ex,
    input  logic [XLEN-1:0] rs1_data_ex,
    input  logic [XLEN-1:0] rs2_data_ex,
    input  alu_op_e         alu_op_ex,
    input  logic            alu_src_ex,
    input  logic            mem_write_ex,
    input  logic            mem_to_reg_ex,
    input  logic            reg_write_ex,
    input  logic            branch_ex,
    input  logic            jal_ex,
    input  logic            jalr_ex,
    input  logic [2:0]      funct3_ex,
    input  fwd_sel_e        fwd_a,
    input  fwd_sel_e        fwd_b,
    input  logic [XLEN-1:0] wb_data,
    output logic            redirect,
    output logic [XLEN-1:0] redirect_pc,
    output logic [XLEN-1:0] alu_result_mem,
    output logic [XLEN-1:0] store_data_mem,
    output reg_idx_t        rd_mem,
    output logic            reg_write_mem,
    output logic            mem_write_mem,
    output logic            mem_to_reg_mem
);
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] ex_result;
    logic            taken;

    function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                 input logic [XLEN-1:0] reg_val,
                                                 input logic [XLEN-1:0] mem_val,
                                                 input logic [XLEN-1:0] wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // ----------------------------------------
    // operand select
    // ----------------------------------------
    assign src_a = fwd_mux(fwd_a, rs1_data_ex, alu_result_mem, wb_data);
    assign src_b = fwd_mux(fwd_b, rs2_data_ex, alu_result_mem, wb_data);
    assign alu_b = alu_src_ex ? imm_ex : src_b;

    // alu
    always_comb begin
        case (alu_op_ex)
            ALU_SUB:    alu_out = src_a - alu_b;
            ALU_AND:    alu_out = src_a & alu_b;
            ALU_OR:     alu_out = src_a | alu_b;
            ALU_XOR:    alu_out = src_a ^ alu_b;
            ALU_SLT:    alu_out = XLEN'($signed(src_a) < $signed(alu_b));
            ALU_SLL:    alu_out = src_a << alu_b[4:0];
            ALU_SRL:    alu_out = src_a >> alu_b[4:0];
            ALU_PASS_B: alu_out = alu_b;
            default:    alu_out = src_a + alu_b;
        endcase
    end

    // ----------------------------------------
    // branch and jump resolution
    // ----------------------------------------
    always_comb begin
        case (funct3_ex)
            F3_BEQ:  taken = (src_a == src_b);
            F3_BNE:  taken = (src_a != src_b);
            F3_BLT:  taken = ($signed(src_a) < $signed(src_b));
            F3_BGE:  taken = !($signed(src_a) < $signed(src_b));
            default: taken = 1'b0;
        endcase
    end

    assign redirect = (branch_ex && taken) || jal_ex || jalr_ex;
    // jalr clears bit 0 of its sum
    assign redirect_pc = jalr_ex ? ((src_a + imm_ex) & ~XLEN'(1)) : (pc_ex + imm_ex);

    // link address for jumps
    assign ex_result = (jal_ex || jalr_ex) ? (pc_ex + XLEN'(4)) : alu_out;

    // ----------------------------------------
    // EX/MEM register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_write_mem  <= 1'b0;
            mem_write_mem  <= 1'b0;
            mem_to_reg_mem <= 1'b0;
        end else begin
            reg_write_mem  <= reg_write_ex;
            mem_write_mem  <= mem_write_ex;
            mem_to_reg_mem <= mem_to_reg_ex;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_mem <= ex_result;
        store_data_mem <= src_b;
        rd_mem         <= rd_ex;
    end

    // only a control transfer redirects, and the flushed slot behind it never does
    assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> (branch_ex || jal_ex || jalr_ex) ##1 !redirect);

endmodule

/* src/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage import rv_isa_pkg::*; #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [XLEN-1:0] alu_result_mem,
    input  logic [XLEN-1:0] store_data_mem,
    input  reg_idx_t        rd_mem,
    input  logic            reg_write_mem,
    input  logic            mem_write_mem,
    input  logic            mem_to_reg_mem,
    output reg_idx_t        rd_wb,
    output logic            reg_write_wb,
    output logic [XLEN-1:0] wb_data
);
    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0]    dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] word_addr;
    logic [XLEN-1:0]    alu_result_wb;
    logic [XLEN-1:0]    load_data_wb;
    logic               mem_to_reg_wb;

    // word addressed, byte offset dropped
    assign word_addr = alu_result_mem[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (mem_write_mem) begin
            dmem[word_addr] <= store_data_mem;
        end
    end

    // ----------------------------------------
    // MEM/WB register
    // ----------------------------------------
    // load data captured straight out of the array
    always_ff @(posedge clk) begin
        alu_result_wb <= alu_result_mem;
        load_data_wb  <= dmem[word_addr];
        rd_wb         <= rd_mem;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_write_wb  <= 1'b0;
            mem_to_reg_wb <= 1'b0;
        end else begin
            reg_write_wb  <= reg_write_mem;
            mem_to_reg_wb <= mem_to_reg_mem;
        end
    end

    // writeback select
    assign wb_data = mem_to_reg_wb ? load_data_wb : alu_result_wb;

    // effective address from execute must land on a word inside the array
    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_write_mem || mem_to_reg_mem) |->
            (alu_result_mem[1:0] == 2'b00) && (alu_result_mem < XLEN'(DMEM_DEPTH * 4)));

endmodule

/* src/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  reg_idx_t rs1_id,
    input  reg_idx_t rs2_id,
    input  reg_idx_t rs1_ex,
    input  reg_idx_t rs2_ex,
    input  reg_idx_t rd_ex,
    input  logic     mem_to_reg_ex,
    input  reg_idx_t rd_mem,
    input  logic     reg_write_mem,
    input  reg_idx_t rd_wb,
    input  logic     reg_write_wb,
    input  logic     redirect,
    output logic     stall,
    output logic     flush,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b
);
    logic load_use;

    // youngest producer first, x0 never forwarded
    function automatic fwd_sel_e fwd_pick(input reg_idx_t src,
                                          input reg_idx_t mem_rd, input logic mem_we,
                                          input reg_idx_t wb_rd, input logic wb_we);
        if (src == '0) begin
            return FWD_NONE;
        end
        if (mem_we && mem_rd == src) begin
            return FWD_MEM;
        end
        if (wb_we && wb_rd == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign fwd_a = fwd_pick(rs1_ex, rd_mem, reg_write_mem, rd_wb, reg_write_wb);
    assign fwd_b = fwd_pick(rs2_ex, rd_mem, reg_write_mem, rd_wb, reg_write_wb);

    // ----------------------------------------
    // load-use stall and redirect flush
    // ----------------------------------------
    assign load_use = mem_to_reg_ex && (rd_ex != '0) &&
                      ((rd_ex == rs1_id) || (rd_ex == rs2_id));

    // redirect wins, the stalled instruction is on the wrong path anyway
    assign stall = load_use && !redirect;
    assign flush = redirect;

    // a load in EX never redirects, so masking should never be needed
    always_comb begin
        assert final (!(load_use && redirect));
    end

endmodule

/* src/rv32i_core.sv */
`timescale 1ns/1ps

module rv32i_core import rv_isa_pkg::*, pipe_ctrl_pkg::*; #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            imem_we,
    input  logic [7:0]      imem_waddr,
    input  logic [XLEN-1:0] imem_wdata,
    output logic [XLEN-1:0] pc,
    output logic            wb_reg_write,
    output reg_idx_t        wb_rd,
    output logic [XLEN-1:0] wb_data
);
    // ----------------------------------------
    // IF/ID and hazard wires
    // ----------------------------------------
    logic [XLEN-1:0] instr_id;
    logic [XLEN-1:0] pc_id;
    logic            stall;
    logic            flush;
    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;
    reg_idx_t        rs1_id;
    reg_idx_t        rs2_id;

    // ID/EX
    reg_idx_t        rs1_ex;
    reg_idx_t        rs2_ex;
    reg_idx_t        rd_ex;
    logic [XLEN-1:0] imm_ex;
    logic [XLEN-1:0] pc_ex;
    logic [XLEN-1:0] rs1_data_ex;
    logic [XLEN-1:0] rs2_data_ex;
    alu_op_e         alu_op_ex;
    logic            alu_src_ex;
    logic            mem_write_ex;
    logic            mem_to_reg_ex;
    logic            reg_write_ex;
    logic            branch_ex;
    logic            jal_ex;
    logic            jalr_ex;
    logic [2:0]      funct3_ex;

    // EX/MEM and redirect
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    logic [XLEN-1:0] alu_result_mem;
    logic [XLEN-1:0] store_data_mem;
    reg_idx_t        rd_mem;
    logic            reg_write_mem;
    logic            mem_write_mem;
    logic            mem_to_reg_mem;

    // ----------------------------------------
    // stages
    // ----------------------------------------
    fetch_stage #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) fetch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_we     (imem_we),
        .imem_waddr  (imem_waddr),
        .imem_wdata  (imem_wdata),
        .stall       (stall),
        .flush       (flush),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc),
        .pc_id       (pc_id),
        .instr_id    (instr_id)
    );

    // writeback goes straight back into the register file
    decode_stage decode_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_id      (instr_id),
        .pc_id         (pc_id),
        .stall         (stall),
        .flush         (flush),
        .rd_wb         (wb_rd),
        .reg_write_wb  (wb_reg_write),
        .wb_data       (wb_data),
        .rs1_id        (rs1_id),
        .rs2_id        (rs2_id),
        .rs1_ex        (rs1_ex),
        .rs2_ex        (rs2_ex),
        .rd_ex         (rd_ex),
        .imm_ex        (imm_ex),
        .pc_ex         (pc_ex),
        .rs1_data_ex   (rs1_data_ex),
        .rs2_data_ex   (rs2_data_ex),
        .alu_op_ex     (alu_op_ex),
        .alu_src_ex    (alu_src_ex),
        .mem_write_ex  (mem_write_ex),
        .mem_to_reg_ex (mem_to_reg_ex),
        .reg_write_ex  (reg_write_ex),
        .branch_ex     (branch_ex),
        .jal_ex        (jal_ex),
        .jalr_ex       (jalr_ex),
        .funct3_ex     (funct3_ex)
    );

    hazard_unit hazard_i (
        .rs1_id        (rs1_id),
        .rs2_id        (rs2_id),
        .rs1_ex        (rs1_ex),
        .rs2_ex        (rs2_ex),
        .rd_ex         (rd_ex),
        .mem_to_reg_ex (mem_to_reg_ex),
        .rd_mem        (rd_mem),
        .reg_write_mem (reg_write_mem),
        .rd_wb         (wb_rd),
        .reg_write_wb  (wb_reg_write),
        .redirect      (redirect),
        .stall         (stall),
        .flush         (flush),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b)
    );

    execute_stage execute_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_ex          (rd_ex),
        .imm_ex         (imm_ex),
        .pc_ex          (pc_ex),
        .rs1_data_ex    (rs1_data_ex),
        .rs2_data_ex    (rs2_data_ex),
        .alu_op_ex      (alu_op_ex),
        .alu_src_ex     (alu_src_ex),
        .mem_write_ex   (mem_write_ex),
        .mem_to_reg_ex  (mem_to_reg_ex),
        .reg_write_ex   (reg_write_ex),
        .branch_ex      (branch_ex),
        .jal_ex         (jal_ex),
        .jalr_ex        (jalr_ex),
        .funct3_ex      (funct3_ex),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .wb_data        (wb_data),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .alu_result_mem (alu_result_mem),
        .store_data_mem (store_data_mem),
        .rd_mem         (rd_mem),
        .reg_write_mem  (reg_write_mem),
        .mem_write_mem  (mem_write_mem),
        .mem_to_reg_mem (mem_to_reg_mem)
    );

    mem_stage #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) mem_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .alu_result_mem (alu_result_mem),
        .store_data_mem (store_data_mem),
        .rd_mem         (rd_mem),
        .reg_write_mem  (reg_write_mem),
        .mem_write_mem  (mem_write_mem),
        .mem_to_reg_mem (mem_to_reg_mem),
        .rd_wb          (wb_rd),
        .reg_write_wb   (wb_reg_write),
        .wb_data        (wb_data)
    );

endmodule

/* verification/tb_rv32i_core.sv */
`timescale 1ns/1ps

module tb_rv32i_core import rv_isa_pkg::*; ();

    localparam int IMEM_DEPTH   = 256;
    localparam int DMEM_DEPTH   = 256;
    localparam int STIM_DEPTH   = 512;
    localparam int CLK_HALF     = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 4;
    // long enough to see the final self-loop come round several times
    localparam int LOOP_WATCH   = 12;

    logic            clk;
    logic            rst_n;
    logic            imem_we;
    logic [7:0]      imem_waddr;
    logic [XLEN-1:0] imem_wdata;
    logic [XLEN-1:0] pc;
    logic            wb_reg_write;
    reg_idx_t        wb_rd;
    logic [XLEN-1:0] wb_data;

    // raw words of the data file
    logic [XLEN-1:0] stim [STIM_DEPTH];
    // expected retirement records in program order
    reg_idx_t        exp_rd_q [$];
    logic [XLEN-1:0] exp_data_q [$];
    logic [XLEN-1:0] final_pc;
    int              prog_len      = 0;
    int              rec_count     = 0;
    int              rec_index     = 0;
    int              cycle_count   = 0;
    int              timeout_limit = 0;

    rv32i_core #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_we      (imem_we),
        .imem_waddr   (imem_waddr),
        .imem_wdata   (imem_wdata),
        .pc           (pc),
        .wb_reg_write (wb_reg_write),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ----------------------------------------
    // failure and compare helpers
    // ----------------------------------------
    task automatic report_failure();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_rd(input reg_idx_t expected, input reg_idx_t actual, input int idx);
        if (actual !== expected) begin
            $display("FAILED wb_rd (record %0d): expected 0x%h got 0x%h", idx, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_word(input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual,
                              input int idx);
        if (actual !== expected) begin
            $display("FAILED wb_data (record %0d): expected 0x%h got 0x%h",
                     idx, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_pc(input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED pc: expected 0x%h got 0x%h", expected, actual);
            report_failure();
        end
    endtask

    // ----------------------------------------
    // data file and program load
    // ----------------------------------------
    // word count and record count first, then program words, (rd, data) pairs and final pc
    task automatic read_stimulus();
        int base;
        $readmemh("verification/core_input.txt", stim);
        prog_len  = int'(stim[0]);
        rec_count = int'(stim[1]);
        if ($isunknown(stim[0]) || $isunknown(stim[1]) || prog_len == 0 ||
            prog_len > IMEM_DEPTH || 3 + prog_len + 2 * rec_count > STIM_DEPTH) begin
            $display("stimulus file is missing or its header is not usable");
            report_failure();
        end
        base = 2 + prog_len;
        for (int i = 0; i < rec_count; i++) begin
            exp_rd_q.push_back(reg_idx_t'(stim[base + 2 * i]));
            exp_data_q.push_back(stim[base + 2 * i + 1]);
        end
        final_pc = stim[base + 2 * rec_count];
        if ($isunknown(final_pc)) begin
            $display("stimulus file ends before the final pc");
            report_failure();
        end
        // every instruction may cost a stall or a flush on top of pipeline fill
        timeout_limit = prog_len * 8 + 50;
    endtask

    // one word per cycle while the core is still held in reset
    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            imem_we    = 1'b1;
            imem_waddr = 8'(i);
            imem_wdata = stim[2 + i];
        end
        @(posedge clk);
        #DRIVE_DELAY;
        imem_we = 1'b0;
    endtask

    // ----------------------------------------
    // writeback checker sampling at mid-cycle
    // ----------------------------------------
    always @(negedge clk) begin
        if (rst_n && wb_reg_write) begin
            if (exp_rd_q.size() == 0) begin
                $display("writeback to x%0d seen after all expected records", wb_rd);
                report_failure();
            end else begin
                check_rd(exp_rd_q.pop_front(), wb_rd, rec_index);
                check_word(exp_data_q.pop_front(), wb_data, rec_index);
                rec_index = rec_index + 1;
            end
        end
    end

    // cycle budget counted from reset release
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > timeout_limit) begin
                $display("timeout, program did not finish within %0d cycles", timeout_limit);
                report_failure();
            end
        end
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        logic [XLEN-1:0] lowest_pc;
        rst_n      = 1'b0;
        imem_we    = 1'b0;
        imem_waddr = '0;
        imem_wdata = '0;
        read_stimulus();
        load_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // drain all expected records
        while (exp_rd_q.size() != 0) begin
            @(negedge clk);
        end

        // wrong-path fetches sit above the loop head
        lowest_pc = pc;
        repeat (LOOP_WATCH) begin
            @(negedge clk);
            if (pc < lowest_pc) begin
                lowest_pc = pc;
            end
        end
        check_pc(final_pc, lowest_pc);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* verification/core_input.txt */
// header: program word count, record count; then one program word per line
// then one record per line as rd and data; last line is the final pc
2c 17
00500093 // 00 addi x1, x0, 5
ffd00113 // 04 addi x2, x0, -3
002081b3 // 08 add  x3, x1, x2
40208233 // 0c sub  x4, x1, x2
001122b3 // 10 slt  x5, x2, x1
0020a333 // 14 slt  x6, x1, x2
0040f3b3 // 18 and  x7, x1, x4
0040e433 // 1c or   x8, x1, x4
001444b3 // 20 xor  x9, x8, x1
00309533 // 24 sll  x10, x1, x3
003155b3 // 28 srl  x11, x2, x3
0f017613 // 2c andi x12, x2, 0xf0
ff00e693 // 30 ori  x13, x1, -16
7ff0c713 // 34 xori x14, x1, 0x7ff
ffe12793 // 38 slti x15, x2, -2
12345837 // 3c lui  x16, 0x12345
00708013 // 40 addi x0, x1, 7
010008b3 // 44 add  x17, x0, x16
01002423 // 48 sw   x16, 8(x0)
00802903 // 4c lw   x18, 8(x0)
00190993 // 50 addi x19, x18, 1
00108663 // 54 beq  x1, x1, +12
06300a13 // 58 addi x20, x0, 99
06200a13 // 5c addi x20, x0, 98
00109463 // 60 bne  x1, x1, +8
00100a93 // 64 addi x21, x0, 1
00114463 // 68 blt  x2, x1, +8
00200a93 // 6c addi x21, x0, 2
00115463 // 70 bge  x2, x1, +8
00209463 // 74 bne  x1, x2, +8
00300b13 // 78 addi x22, x0, 3
0020d463 // 7c bge  x1, x2, +8
00400b13 // 80 addi x22, x0, 4
00208463 // 84 beq  x1, x2, +8
0020c463 // 88 blt  x1, x2, +8
00c00bef // 8c jal  x23, +12
00700c13 // 90 addi x24, x0, 7
00800c13 // 94 addi x24, x0, 8
010b8ce7 // 98 jalr x25, 16(x23)
00900d13 // 9c addi x26, x0, 9
000c8d33 // a0 add  x26, x25, x0
0000006f // a4 jal  x0, 0
00000013 // a8 nop
00000013 // ac nop
01 00000005
02 fffffffd
03 00000002
04 00000008
05 00000001
06 00000000
07 00000000
08 0000000d
09 00000008
0a 00000014
0b 3fffffff
0c 000000f0
0d fffffff5
0e 000007fa
0f 00000001
10 12345000
11 12345000
12 12345000
13 12345001
15 00000001
17 00000090
19 0000009c
1a 0000009c
000000a4

/* filelist.f */
common/rv_isa_pkg.sv
common/pipe_ctrl_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_stage.sv
src/hazard_unit.sv
src/rv32i_core.sv
verification/tb_rv32i_core.sv

/* Bender.yml */
package:
  name: rv32i_core

sources:
  # shared packages
  - common/rv_isa_pkg.sv
  - common/pipe_ctrl_pkg.sv
  # pipeline RTL
  - src/fetch_stage.sv
  - src/decode_stage.sv
  - src/execute_stage.sv
  - src/mem_stage.sv
  - src/hazard_unit.sv
  - src/rv32i_core.sv
  # testbench
  - target: simulation
    files:
      - verification/tb_rv32i_core.sv
